//--- design/exu_pkg.sv
package exu_pkg;

  // major opcodes, inst[6:2]
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_CALRI  = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_CALRR  = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYS    = 5'b11100
  } op_t;

  // branch funct3
  localparam logic [2:0] BR_BEQ  = 3'b000;
  localparam logic [2:0] BR_BNE  = 3'b001;
  localparam logic [2:0] BR_BLT  = 3'b100;
  localparam logic [2:0] BR_BGE  = 3'b101;
  localparam logic [2:0] BR_BLTU = 3'b110;
  localparam logic [2:0] BR_BGEU = 3'b111;

  // load/store width and sign, same as funct3
  localparam logic [2:0] MEM_FN_B  = 3'b000;
  localparam logic [2:0] MEM_FN_H  = 3'b001;
  localparam logic [2:0] MEM_FN_W  = 3'b010;
  localparam logic [2:0] MEM_FN_BU = 3'b100;
  localparam logic [2:0] MEM_FN_HU = 3'b101;

  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;
  localparam logic [31:0] CAUSE_ECALL = 32'd11;

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned MEM_WORDS = 256;           // 1 KiB data memory
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

  typedef struct packed {
    logic [31:0] pc;
    op_t         opcode;
    logic [2:0]  funct;
    logic [4:0]  rd;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] imm;
    logic [31:0] csr;        // csr read value, address sits in imm[11:0]
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [2:0]  alu_funct;
    logic        alu_funcs;
  } issue_t;

  typedef struct packed {
    logic              write;
    logic [2:0]        fn;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;
  } mem_req_t;

endpackage

//--- design/decouple_if.sv
`timescale 1ns/100ps

// valid/ready link, data held stable while valid waits for ready
interface decouple_if #(
  parameter type T = logic [31:0]
);
  logic valid;
  logic ready;
  T     data;

  modport out (
    output valid, data,
    input  ready
  );

  modport in (
    input  valid, data,
    output ready
  );
endinterface

//--- design/apb_if.sv
`timescale 1ns/100ps

interface apb_if;
  import exu_pkg::*;

  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [31:0]       pwdata;
  logic [3:0]        pstrb;    // zero on reads
  logic [31:0]       prdata;
  logic              pready;

  modport master (
    output psel, penable, pwrite, paddr, pwdata, pstrb,
    input  prdata, pready
  );

  modport slave (
    input  psel, penable, pwrite, paddr, pwdata, pstrb,
    output prdata, pready
  );
endinterface

//--- design/alu.sv
`timescale 1ns/100ps

module alu (
  input  logic [31:0] alu_a,
  input  logic [31:0] alu_b,
  input  logic [2:0]  funct,
  input  logic        funcs,
  output logic [31:0] val
);

  logic [4:0]  shamt;
  logic [31:0] sra_val;
  logic        lt_s;
  logic        lt_u;

  assign shamt   = alu_b[4:0];
  assign sra_val = $signed(alu_a) >>> shamt;   // kept apart so the shift stays signed
  assign lt_s    = $signed(alu_a) < $signed(alu_b);
  assign lt_u    = alu_a < alu_b;

  // funct follows RV32I funct3
  always_comb begin
    case (funct)
      3'b000: val = funcs ? alu_a - alu_b : alu_a + alu_b;
      3'b001: val = alu_a << shamt;
      3'b010: val = {31'd0, lt_s};     // slt, also blt/bge
      3'b011: val = {31'd0, lt_u};     // sltu, also bltu/bgeu
      3'b100: val = alu_a ^ alu_b;
      3'b101: begin
        if (funcs) begin
          val = sra_val;
        end else begin
          val = alu_a >> shamt;
        end
      end
      3'b110: val = alu_a | alu_b;
      default: val = alu_a & alu_b;
    endcase
  end

endmodule

//--- design/exu.sv
`timescale 1ns/100ps

module exu (
  input  logic        clk,
  input  logic        rstn,
  decouple_if.in      issue,
  decouple_if.out     mreq,
  decouple_if.in      mres,
  output logic [31:0] npc,
  output logic        gpr_wen,
  output logic [4:0]  gpr_waddr,
  output logic [31:0] gpr_wdata,
  output logic        csr_wen1,
  output logic [11:0] csr_waddr1,
  output logic [31:0] csr_wdata1,
  output logic        csr_wen2,
  output logic [11:0] csr_waddr2,
  output logic [31:0] csr_wdata2
);
  import exu_pkg::*;

  issue_t      ins;
  logic [31:0] alu_val;
  logic        id_gpr_wen;
  logic [31:0] id_gpr_wdata;
  logic [11:0] csr_addr;
  logic        is_sys;
  logic        ecall;
  logic        csr_jump;
  logic        br_en;
  logic [31:0] pc_inc;
  logic [31:0] npc_base;
  logic [31:0] npc_sum;
  logic        is_mem;
  logic        issue_hs;
  logic        mres_hs;
  logic        busy;     // memory op in flight
  logic        load_q;

  assign ins = issue.data;

  alu u_alu (
    .alu_a (ins.alu_a),
    .alu_b (ins.alu_b),
    .funct (ins.alu_funct),
    .funcs (ins.alu_funcs),
    .val   (alu_val)
  );

  // loads write rd later, from the response
  always_comb begin
    case (ins.opcode)
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_CALRI, OP_CALRR: id_gpr_wen = 1'b1;
      OP_SYS:  id_gpr_wen = |ins.funct;    // csr ops only
      default: id_gpr_wen = 1'b0;
    endcase
  end
  assign id_gpr_wdata = is_sys ? ins.csr : alu_val;   // old csr value to rd

  assign csr_addr = ins.imm[11:0];
  assign is_sys   = ins.opcode == OP_SYS;
  assign ecall    = is_sys & (ins.funct == 3'b000) & (csr_addr == 12'd0);
  assign csr_jump = is_sys & (ins.funct == 3'b000);    // ecall or mret

  // branch decision from the alu compare result
  always_comb begin
    case (ins.funct)
      BR_BEQ:          br_en = ~|alu_val;
      BR_BNE:          br_en =  |alu_val;
      BR_BLT, BR_BLTU: br_en =  alu_val[0];
      BR_BGE, BR_BGEU: br_en = ~alu_val[0];
      default:         br_en = 1'b0;
    endcase
  end

  always_comb begin
    case (ins.opcode)
      OP_JAL, OP_JALR: pc_inc = ins.imm;
      OP_BRANCH:       pc_inc = br_en ? ins.imm : 32'd4;
      OP_SYS:          pc_inc = csr_jump ? 32'd0 : 32'd4;
      default:         pc_inc = 32'd4;
    endcase
  end

  assign npc_base = csr_jump ? ins.csr : (ins.opcode == OP_JALR) ? ins.src1 : ins.pc;
  assign npc_sum  = npc_base + pc_inc;
  assign npc      = {npc_sum[31:1], 1'b0};

  assign is_mem   = (ins.opcode == OP_LOAD) | (ins.opcode == OP_STORE);
  assign issue_hs = issue.valid & issue.ready;
  assign mres_hs  = mres.valid & mres.ready;

  assign issue.ready = ~busy;
  assign mres.ready  = busy;

  always_ff @(posedge clk) begin
    if (rstn) begin
      busy       <= 1'b0;
      load_q     <= 1'b0;
      mreq.valid <= 1'b0;
      gpr_wen    <= 1'b0;
      csr_wen1   <= 1'b0;
      csr_wen2   <= 1'b0;
    end else begin
      gpr_wen  <= 1'b0;     // write pulses last one cycle
      csr_wen1 <= 1'b0;
      csr_wen2 <= 1'b0;
      if (mreq.valid & mreq.ready) mreq.valid <= 1'b0;
      if (issue_hs) begin
        gpr_wen  <= id_gpr_wen;
        csr_wen1 <= is_sys & ((|ins.funct) | ecall);
        csr_wen2 <= ecall;
        if (is_mem) begin
          busy       <= 1'b1;
          mreq.valid <= 1'b1;
          load_q     <= ins.opcode == OP_LOAD;
        end
      end
      if (mres_hs) begin
        busy    <= 1'b0;
        gpr_wen <= load_q;
      end
    end
  end

  // gpr_waddr keeps the load rd until the response
  always_ff @(posedge clk) begin
    if (issue_hs) begin
      gpr_waddr  <= ins.rd;
      gpr_wdata  <= id_gpr_wdata;
      csr_waddr1 <= ecall ? CSR_MEPC : csr_addr;
      csr_wdata1 <= ecall ? ins.pc : alu_val;
      csr_waddr2 <= CSR_MCAUSE;
      csr_wdata2 <= CAUSE_ECALL;
      if (is_mem) begin
        mreq.data <= '{write: ins.opcode == OP_STORE, fn: ins.funct,
                       addr: alu_val, wdata: ins.src2};
      end
    end
    if (mres_hs) gpr_wdata <= mres.data;
  end

endmodule

//--- design/lsu.sv
`timescale 1ns/100ps

module lsu (
  input  logic    clk,
  input  logic    rstn,
  decouple_if.in  mreq,
  decouple_if.out mres,
  apb_if.master   apb
);
  import exu_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS, S_RESP} state_t;

  state_t      state;
  mem_req_t    req;
  logic [4:0]  sh;        // byte lane offset in bits
  logic [31:0] lane;
  logic [31:0] load_val;

  assign sh = {req.addr[1:0], 3'b000};

  assign mreq.ready  = state == S_IDLE;
  assign mres.valid  = state == S_RESP;

  assign apb.psel    = (state == S_SETUP) | (state == S_ACCESS);
  assign apb.penable = state == S_ACCESS;
  assign apb.pwrite  = req.write;
  assign apb.paddr   = {req.addr[ADDR_W-1:2], 2'b00};
  assign apb.pwdata  = req.wdata << sh;

  always_comb begin
    apb.pstrb = 4'b0000;
    if (req.write) begin
      case (req.fn)
        MEM_FN_B, MEM_FN_BU: apb.pstrb = 4'b0001 << req.addr[1:0];
        MEM_FN_H, MEM_FN_HU: apb.pstrb = 4'b0011 << req.addr[1:0];
        MEM_FN_W:            apb.pstrb = 4'b1111;
        default:             apb.pstrb = 4'b0000;
      endcase
    end
  end

  assign lane = apb.prdata >> sh;

  always_comb begin
    case (req.fn)
      MEM_FN_B:  load_val = {{24{lane[7]}}, lane[7:0]};
      MEM_FN_BU: load_val = {24'd0, lane[7:0]};
      MEM_FN_H:  load_val = {{16{lane[15]}}, lane[15:0]};
      MEM_FN_HU: load_val = {16'd0, lane[15:0]};
      MEM_FN_W:  load_val = lane;
      default:   load_val = lane;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:   if (mreq.valid) state <= S_SETUP;
        S_SETUP:  state <= S_ACCESS;
        S_ACCESS: if (apb.pready) state <= S_RESP;
        default:  if (mres.ready) state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mreq.valid & mreq.ready) req <= mreq.data;
    if ((state == S_ACCESS) & apb.pready) mres.data <= req.write ? 32'd0 : load_val;
  end

endmodule

//--- design/apb_arbiter.sv
`timescale 1ns/100ps

module apb_arbiter (
  input  logic clk,
  input  logic rstn,
  apb_if.slave  m0,
  apb_if.slave  m1,
  apb_if.master s
);

  logic active;   // a transfer owns the slave
  logic owner;
  logic prio;     // preferred master when both request
  logic pick;
  logic sel;
  logic done;

  assign pick = (m0.psel & m1.psel) ? prio : m1.psel;
  assign sel  = active ? owner : pick;

  // penable held low in the grant cycle gives the slave its setup phase
  assign s.psel    = sel ? m1.psel : m0.psel;
  assign s.penable = active & (sel ? m1.penable : m0.penable);
  assign s.pwrite  = sel ? m1.pwrite : m0.pwrite;
  assign s.paddr   = sel ? m1.paddr : m0.paddr;
  assign s.pwdata  = sel ? m1.pwdata : m0.pwdata;
  assign s.pstrb   = sel ? m1.pstrb : m0.pstrb;

  assign m0.pready = active & ~owner & s.pready;
  assign m1.pready = active & owner & s.pready;
  assign m0.prdata = (active & ~owner) ? s.prdata : 32'd0;
  assign m1.prdata = (active & owner) ? s.prdata : 32'd0;

  assign done = active & s.penable & s.pready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      active <= 1'b0;
      owner  <= 1'b0;
      prio   <= 1'b0;
    end else if (!active) begin
      if (m0.psel | m1.psel) begin
        active <= 1'b1;
        owner  <= pick;
      end
    end else if (done) begin
      active <= 1'b0;
      prio   <= ~owner;   // other master first next time
    end
  end

endmodule

//--- design/data_mem.sv
`timescale 1ns/100ps

module data_mem (
  input  logic clk,
  input  logic rstn,
  apb_if.slave apb
);
  import exu_pkg::*;

  logic [31:0]       mem [MEM_WORDS];
  logic [MEM_AW-1:0] idx;      // address wraps at 1 KiB
  logic              access;
  logic              wait_q;   // high in the second access cycle
  logic [31:0]       rdata_q;

  assign idx        = apb.paddr[MEM_AW+1:2];
  assign access     = apb.psel & apb.penable;
  assign apb.pready = access & wait_q;
  assign apb.prdata = rdata_q;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access & ~wait_q;
    end
  end

  always_ff @(posedge clk) begin
    if (access & ~wait_q) rdata_q <= mem[idx];   // read in the wait cycle
    if (apb.pready & apb.pwrite) begin
      for (int i = 0; i < 4; i++) begin
        if (apb.pstrb[i]) mem[idx][8*i +: 8] <= apb.pwdata[8*i +: 8];
      end
    end
  end

endmodule

//--- design/exec_top.sv
`timescale 1ns/100ps

module exec_top (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      issue_valid,
  output logic                      issue_ready,
  input  logic [31:0]               pc,
  input  logic [4:0]                opcode,
  input  logic [2:0]                funct,
  input  logic [4:0]                rd,
  input  logic [31:0]               src1,
  input  logic [31:0]               src2,
  input  logic [31:0]               imm,
  input  logic [31:0]               csr,
  input  logic [31:0]               alu_a,
  input  logic [31:0]               alu_b,
  input  logic [2:0]                alu_funct,
  input  logic                      alu_funcs,
  output logic [31:0]               npc,
  output logic                      gpr_wen,
  output logic [4:0]                gpr_waddr,
  output logic [31:0]               gpr_wdata,
  output logic                      csr_wen1,
  output logic [11:0]               csr_waddr1,
  output logic [31:0]               csr_wdata1,
  output logic                      csr_wen2,
  output logic [11:0]               csr_waddr2,
  output logic [31:0]               csr_wdata2,
  input  logic                      host_psel,
  input  logic                      host_penable,
  input  logic                      host_pwrite,
  input  logic [exu_pkg::ADDR_W-1:0] host_paddr,
  input  logic [31:0]               host_pwdata,
  input  logic [3:0]                host_pstrb,
  output logic [31:0]               host_prdata,
  output logic                      host_pready
);
  import exu_pkg::*;

  decouple_if #(.T(issue_t))      issue ();
  decouple_if #(.T(mem_req_t))    mreq ();
  decouple_if #(.T(logic [31:0])) mres ();
  apb_if lsu_apb ();
  apb_if host_apb ();
  apb_if mem_apb ();

  assign issue.valid = issue_valid;
  assign issue_ready = issue.ready;
  assign issue.data  = '{pc: pc, opcode: op_t'(opcode), funct: funct, rd: rd,
                         src1: src1, src2: src2, imm: imm, csr: csr,
                         alu_a: alu_a, alu_b: alu_b, alu_funct: alu_funct,
                         alu_funcs: alu_funcs};

  // host pins onto the second arbiter port
  assign host_apb.psel    = host_psel;
  assign host_apb.penable = host_penable;
  assign host_apb.pwrite  = host_pwrite;
  assign host_apb.paddr   = host_paddr;
  assign host_apb.pwdata  = host_pwdata;
  assign host_apb.pstrb   = host_pstrb;
  assign host_prdata      = host_apb.prdata;
  assign host_pready      = host_apb.pready;

  exu u_exu (
    .clk        (clk),
    .rstn       (rstn),
    .issue      (issue),
    .mreq       (mreq),
    .mres       (mres),
    .npc        (npc),
    .gpr_wen    (gpr_wen),
    .gpr_waddr  (gpr_waddr),
    .gpr_wdata  (gpr_wdata),
    .csr_wen1   (csr_wen1),
    .csr_waddr1 (csr_waddr1),
    .csr_wdata1 (csr_wdata1),
    .csr_wen2   (csr_wen2),
    .csr_waddr2 (csr_waddr2),
    .csr_wdata2 (csr_wdata2)
  );

  lsu u_lsu (
    .clk  (clk),
    .rstn (rstn),
    .mreq (mreq),
    .mres (mres),
    .apb  (lsu_apb)
  );

  apb_arbiter u_apb_arbiter (
    .clk  (clk),
    .rstn (rstn),
    .m0   (lsu_apb),
    .m1   (host_apb),
    .s    (mem_apb)
  );

  data_mem u_data_mem (
    .clk  (clk),
    .rstn (rstn),
    .apb  (mem_apb)
  );

endmodule

//--- tests/tb_exec_top.sv
`timescale 1ns/100ps

module tb_exec_top;
  import exu_pkg::*;

  logic        clk;
  logic        rstn;
  logic        issue_valid;
  logic        issue_ready;
  logic [31:0] pc;
  logic [4:0]  opcode;
  logic [2:0]  funct;
  logic [4:0]  rd;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [31:0] imm;
  logic [31:0] csr;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [2:0]  alu_funct;
  logic        alu_funcs;
  logic [31:0] npc;
  logic        gpr_wen;
  logic [4:0]  gpr_waddr;
  logic [31:0] gpr_wdata;
  logic        csr_wen1;
  logic [11:0] csr_waddr1;
  logic [31:0] csr_wdata1;
  logic        csr_wen2;
  logic [11:0] csr_waddr2;
  logic [31:0] csr_wdata2;
  logic        host_psel;
  logic        host_penable;
  logic        host_pwrite;
  logic [31:0] host_paddr;
  logic [31:0] host_pwdata;
  logic [3:0]  host_pstrb;
  logic [31:0] host_prdata;
  logic        host_pready;

  // fields of the pending issue line and of its expect line
  logic [31:0] q_pc, q_op, q_fn, q_rd, q_src1, q_src2;
  logic [31:0] q_imm, q_csr, q_a, q_b, q_af, q_fs;
  logic [31:0] e_npc, e_gw, e_rd, e_gdata, e_c1, e_a1, e_d1, e_c2, e_a2, e_d2;
  logic [31:0] h_addr, h_data, h_strb;

  // host access that runs alongside the next issued operation
  logic        par_pending;
  logic        par_write;
  logic [31:0] par_addr, par_data, par_strb;

  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;
  int    cycle_limit = 0;   // stays 0 until the case file is counted
  string lines[$];

  exec_top u_exec_top (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // a short line in the case file would leave stale fields behind
  task automatic check_fields(input int idx, input int got, input int want);
    if (got != want) begin
      errors++;
      $display("case entry %0d has %0d fields, %0d expected", idx, got, want);
    end
  endtask

  // one full APB transfer on the host pins, read data checked against data
  task automatic host_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
    int n;
    @(posedge clk);
    #1;
    host_psel    = 1'b1;        // setup phase
    host_penable = 1'b0;
    host_pwrite  = write;
    host_paddr   = addr;
    host_pwdata  = write ? data : 32'd0;
    host_pstrb   = write ? strb : 4'b0000;
    @(posedge clk);
    #1;
    host_penable = 1'b1;
    n = 0;
    @(negedge clk);
    while (!host_pready && n < 40) begin
      n++;
      @(negedge clk);
    end
    if (!host_pready) begin
      errors++;
      $display("host transfer at address %h never saw pready", addr);
    end else if (!write) begin
      check_value("host_prdata", data, host_prdata);
    end
    @(posedge clk);
    #1;
    host_psel    = 1'b0;
    host_penable = 1'b0;
  endtask

  task automatic run_issue;
    int   n;
    logic is_mem;
    is_mem = (q_op[4:0] == OP_LOAD) || (q_op[4:0] == OP_STORE);
    @(posedge clk);
    #1;
    issue_valid = 1'b1;
    pc          = q_pc;
    opcode      = q_op[4:0];
    funct       = q_fn[2:0];
    rd          = q_rd[4:0];
    src1        = q_src1;
    src2        = q_src2;
    imm         = q_imm;
    csr         = q_csr;
    alu_a       = q_a;
    alu_b       = q_b;
    alu_funct   = q_af[2:0];
    alu_funcs   = q_fs[0];
    n = 0;
    @(negedge clk);
    while (!issue_ready && n < 40) begin
      n++;
      @(negedge clk);
    end
    if (!issue_ready) begin
      errors++;
      $display("issue at pc %h was never accepted", q_pc);
    end
    check_value("npc", e_npc, npc);
    @(posedge clk);             // handshake edge
    #1;
    issue_valid = 1'b0;
    @(negedge clk);
    if (is_mem) begin
      check_value("issue_ready", 32'd0, 32'(issue_ready));
      check_value("gpr_wen", 32'd0, 32'(gpr_wen));
      n = 0;
      while (!issue_ready && n < 40) begin
        n++;
        @(negedge clk);
      end
      if (!issue_ready) begin
        errors++;
        $display("memory operation at pc %h did not complete", q_pc);
      end
    end else begin
      check_value("issue_ready", 32'd1, 32'(issue_ready));
    end
    // write pulse cycle
    check_value("gpr_wen", e_gw, 32'(gpr_wen));
    check_value("csr_wen1", e_c1, 32'(csr_wen1));
    check_value("csr_wen2", e_c2, 32'(csr_wen2));
    if (e_gw[0]) begin
      check_value("gpr_waddr", e_rd, 32'(gpr_waddr));
      check_value("gpr_wdata", e_gdata, gpr_wdata);
    end
    if (e_c1[0]) begin
      check_value("csr_waddr1", e_a1, 32'(csr_waddr1));
      check_value("csr_wdata1", e_d1, csr_wdata1);
    end
    if (e_c2[0]) begin
      check_value("csr_waddr2", e_a2, 32'(csr_waddr2));
      check_value("csr_wdata2", e_d2, csr_wdata2);
    end
    @(negedge clk);
    check_value("gpr_wen", 32'd0, 32'(gpr_wen));      // pulses last one cycle
    check_value("csr_wen1", 32'd0, 32'(csr_wen1));
    check_value("csr_wen2", 32'd0, 32'(csr_wen2));
  endtask

  task automatic run_case;
    if (par_pending) begin
      fork
        run_issue;
        begin
          repeat (2) @(posedge clk);    // host setup meets the lsu setup
          host_access(par_write, par_addr, par_data, par_strb[3:0]);
        end
      join
      par_pending = 1'b0;
    end else begin
      run_issue;
    end
  endtask

  initial begin
    int    fd;
    int    nf;
    int    ncases;
    string line;
    string kind;
    rstn         = 1'b1;
    issue_valid  = 1'b0;
    pc           = '0;
    opcode       = '0;
    funct        = '0;
    rd           = '0;
    src1         = '0;
    src2         = '0;
    imm          = '0;
    csr          = '0;
    alu_a        = '0;
    alu_b        = '0;
    alu_funct    = '0;
    alu_funcs    = 1'b0;
    host_psel    = 1'b0;
    host_penable = 1'b0;
    host_pwrite  = 1'b0;
    host_paddr   = '0;
    host_pwdata  = '0;
    host_pstrb   = '0;
    par_pending  = 1'b0;
    fd = $fopen("tests/exec_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the case file tests/exec_cases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
      end
      $fclose(fd);
    end
    ncases = 0;
    foreach (lines[i]) begin
      nf = $sscanf(lines[i], "%s", kind);
      if (kind != "expect") ncases++;
    end
    cycle_limit = ncases * 40;
    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b0;
    @(negedge clk);
    check_value("issue_ready", 32'd1, 32'(issue_ready));
    check_value("gpr_wen", 32'd0, 32'(gpr_wen));
    check_value("csr_wen1", 32'd0, 32'(csr_wen1));
    check_value("csr_wen2", 32'd0, 32'(csr_wen2));
    check_value("host_pready", 32'd0, 32'(host_pready));
    foreach (lines[i]) begin
      nf = $sscanf(lines[i], "%s", kind);
      if (kind == "issue") begin
        nf = $sscanf(lines[i], "%s %h %h %h %h %h %h %h %h %h %h %h %h", kind, q_pc, q_op,
                     q_fn, q_rd, q_src1, q_src2, q_imm, q_csr, q_a, q_b, q_af, q_fs);
        check_fields(i, nf, 13);
      end else if (kind == "expect") begin
        nf = $sscanf(lines[i], "%s %h %h %h %h %h %h %h %h %h %h", kind, e_npc, e_gw,
                     e_rd, e_gdata, e_c1, e_a1, e_d1, e_c2, e_a2, e_d2);
        check_fields(i, nf, 11);
        run_case;
      end else if (kind == "host_write" || kind == "host_read") begin
        nf = $sscanf(lines[i], "%s %h %h %h", kind, h_addr, h_data, h_strb);
        check_fields(i, nf, 4);
        host_access(kind == "host_write", h_addr, h_data, h_strb[3:0]);
      end else if (kind == "par_write" || kind == "par_read") begin
        nf = $sscanf(lines[i], "%s %h %h %h", kind, par_addr, par_data, par_strb);
        check_fields(i, nf, 4);
        par_write   = kind == "par_write";
        par_pending = 1'b1;
      end else begin
        errors++;
        $display("unknown line kind in the case file: %s", kind);
      end
    end
    repeat (2) @(posedge clk);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- tests/exec_cases.txt
# issue pc op fn rd src1 src2 imm csr alu_a alu_b alu_funct alu_funcs (all hex)
# expect npc gpr_wen rd gpr_wdata csr_wen1 addr1 data1 csr_wen2 addr2 data2
# host_write/par_write addr data strb, host_read/par_read addr expected_word
issue 00000100 0d 0 01 00000000 00000000 12345000 00000000 00000000 12345000 0 0
expect 00000104 1 01 12345000 0 000 00000000 0 000 00000000
issue 00000104 05 0 02 00000000 00000000 00002000 00000000 00000104 00002000 0 0
expect 00000108 1 02 00002104 0 000 00000000 0 000 00000000
issue 00000108 04 0 03 00000010 00000000 fffffff0 00000000 00000010 fffffff0 0 0
expect 0000010c 1 03 00000000 0 000 00000000 0 000 00000000
issue 0000010c 04 5 04 80000000 00000000 00000404 00000000 80000000 00000004 5 1
expect 00000110 1 04 f8000000 0 000 00000000 0 000 00000000
issue 00000110 0c 0 05 00000005 00000007 00000000 00000000 00000005 00000007 0 1
expect 00000114 1 05 fffffffe 0 000 00000000 0 000 00000000
issue 00000114 0c 3 06 00000001 ffffffff 00000000 00000000 00000001 ffffffff 3 0
expect 00000118 1 06 00000001 0 000 00000000 0 000 00000000
issue 00000200 18 0 00 0000000a 0000000a 00000010 00000000 0000000a 0000000a 0 1
expect 00000210 0 00 00000000 0 000 00000000 0 000 00000000
issue 00000210 18 1 00 0000000a 0000000a 00000010 00000000 0000000a 0000000a 0 1
expect 00000214 0 00 00000000 0 000 00000000 0 000 00000000
issue 00000214 18 4 00 ffffffff 00000001 fffffff8 00000000 ffffffff 00000001 2 0
expect 0000020c 0 00 00000000 0 000 00000000 0 000 00000000
issue 0000020c 18 5 00 ffffffff 00000001 fffffff8 00000000 ffffffff 00000001 2 0
expect 00000210 0 00 00000000 0 000 00000000 0 000 00000000
issue 00000210 18 6 00 ffffffff 00000001 00000020 00000000 ffffffff 00000001 3 0
expect 00000214 0 00 00000000 0 000 00000000 0 000 00000000
issue 00000214 18 7 00 ffffffff 00000001 00000020 00000000 ffffffff 00000001 3 0
expect 00000234 0 00 00000000 0 000 00000000 0 000 00000000
issue 00000300 1b 0 01 00000000 00000000 00000100 00000000 00000300 00000004 0 0
expect 00000400 1 01 00000304 0 000 00000000 0 000 00000000
issue 00000400 19 0 01 00001001 00000000 00000004 00000000 00000400 00000004 0 0
expect 00001004 1 01 00000404 0 000 00000000 0 000 00000000
issue 00000500 1c 1 07 cafe0000 00000000 00000340 11112222 cafe0000 00000000 6 0
expect 00000504 1 07 11112222 1 340 cafe0000 0 000 00000000
issue 00000504 1c 0 00 00000000 00000000 00000000 00000800 00000000 00000000 0 0
expect 00000800 0 00 00000000 1 341 00000504 1 342 0000000b
issue 00000800 1c 0 00 00000000 00000000 00000302 00000508 00000000 00000000 0 0
expect 00000508 0 00 00000000 0 000 00000000 0 000 00000000
host_write 00000040 11223344 f
issue 00000600 08 0 00 00000040 000000a5 00000001 00000000 00000040 00000001 0 0
expect 00000604 0 00 00000000 0 000 00000000 0 000 00000000
host_read 00000040 1122a544 0
issue 00000604 00 0 08 00000040 00000000 00000001 00000000 00000040 00000001 0 0
expect 00000608 1 08 ffffffa5 0 000 00000000 0 000 00000000
issue 00000608 00 4 09 00000040 00000000 00000001 00000000 00000040 00000001 0 0
expect 0000060c 1 09 000000a5 0 000 00000000 0 000 00000000
issue 0000060c 08 1 00 00000040 00008001 00000002 00000000 00000040 00000002 0 0
expect 00000610 0 00 00000000 0 000 00000000 0 000 00000000
host_read 00000040 8001a544 0
issue 00000610 00 1 0a 00000040 00000000 00000002 00000000 00000040 00000002 0 0
expect 00000614 1 0a ffff8001 0 000 00000000 0 000 00000000
issue 00000614 00 5 0b 00000040 00000000 00000002 00000000 00000040 00000002 0 0
expect 00000618 1 0b 00008001 0 000 00000000 0 000 00000000
issue 00000618 08 2 00 00000040 deadbeef 00000004 00000000 00000040 00000004 0 0
expect 0000061c 0 00 00000000 0 000 00000000 0 000 00000000
issue 0000061c 00 2 0c 00000040 00000000 00000004 00000000 00000040 00000004 0 0
expect 00000620 1 0c deadbeef 0 000 00000000 0 000 00000000
par_write 00000080 5a5a5a5a f
issue 00000620 08 2 00 00000080 01020304 00000004 00000000 00000080 00000004 0 0
expect 00000624 0 00 00000000 0 000 00000000 0 000 00000000
par_read 00000044 deadbeef 0
issue 00000624 00 2 0d 00000080 00000000 00000000 00000000 00000080 00000000 0 0
expect 00000628 1 0d 5a5a5a5a 0 000 00000000 0 000 00000000
host_read 00000084 01020304 0
issue 00000628 00 2 0e 00000400 00000000 00000044 00000000 00000400 00000044 0 0
expect 0000062c 1 0e deadbeef 0 000 00000000 0 000 00000000

//--- files.f
design/exu_pkg.sv
design/decouple_if.sv
design/apb_if.sv
design/alu.sv
design/exu.sv
design/lsu.sv
design/apb_arbiter.sv
design/data_mem.sv
design/exec_top.sv
tests/tb_exec_top.sv

//--- Makefile
TOP = tb_exec_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f files.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
